//--- all.f
+incdir+design
design/obj_pkg.sv
design/obj_table_ram.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_line_buffer.sv
design/obj_video.sv
testbench/obj_video_props.sv
testbench/obj_video_tb.sv

//--- testbench/obj_video_tb.sv
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_video_tb;

    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 1300 * 2;
    localparam obj_pkg::obj_pix_t BLANK = {8'h00, `OBJ_TRANSPARENT};  // Empty cell

    logic               clk = 1'b0;
    logic               rst;
    obj_pkg::tbl_addr_t cpu_addr;
    obj_pkg::tbl_word_t cpu_din, cpu_dout;
    logic               cpu_we;
    logic               hstart;
    obj_pkg::vpos_t     vrender;
    obj_pkg::xpos_t     hdump;
    obj_pkg::rom_addr_t rom_addr;
    obj_pkg::rom_word_t rom_data;
    obj_pkg::obj_pix_t  pix;

    obj_pkg::rom_word_t rom_mem [0:4095];
    obj_pkg::obj_pix_t  exp_line [0:511];  // Model of the drawn line
    obj_pkg::obj_pix_t  got_line [0:511];

    int    cycle_cnt = 0;
    int    err_cnt = 0;
    int    fail_cnt = 0;
    int    start_errs;
    string test_name;

    obj_video UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Array indexed by the low bits, upper bits scramble the word so the bank shows up
    function automatic obj_pkg::rom_word_t rom_word(input obj_pkg::rom_addr_t a);
        return rom_mem[a[11:0]] ^ 16'(a[17:12]);
    endfunction

    // Graphics ROM, data one cycle after the address
    always @(posedge clk) rom_data <= #2 rom_word(rom_addr);

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic obj_pkg::tbl_addr_t word_addr(input int n, input int w);
        return obj_pkg::tbl_addr_t'(n * 8 + w);
    endfunction

    task automatic fill_rom();
        logic [15:0]        lfsr;
        obj_pkg::rom_word_t w;
        lfsr = 16'd16680;
        for (int a = 0; a < 4096; a++) begin
            w = '0;
            for (int b = 0; b < 16; b++) begin
                lfsr = lfsr_next(lfsr);  // One step per bit
                w    = {w[14:0], lfsr[0]};
            end
            rom_mem[a] = w;
        end
    endtask

    // All bus tasks start and end 2 ns after a rising edge
    task automatic cpu_write(input obj_pkg::tbl_addr_t a, input obj_pkg::tbl_word_t d);
        cpu_addr = a;
        cpu_din  = d;
        cpu_we   = 1'b1;
        @(posedge clk);
        #2;
        cpu_we = 1'b0;
    endtask

    task automatic cpu_read(input obj_pkg::tbl_addr_t a, output obj_pkg::tbl_word_t d);
        cpu_addr = a;
        @(posedge clk);
        #2;
        d = cpu_dout;  // Registered read
    endtask

    task automatic load_entry(input int n, input logic [7:0] top, input logic [7:0] bottom,
                              input obj_pkg::xpos_t x, input obj_pkg::tbl_word_t pitch,
                              input obj_pkg::tbl_word_t start, input obj_pkg::pal_t pal,
                              input obj_pkg::bank_t bank, input obj_pkg::prio_t prio);
        cpu_write(word_addr(n, 0), {bottom, top});
        cpu_write(word_addr(n, 1), 16'(x));
        cpu_write(word_addr(n, 2), pitch);
        cpu_write(word_addr(n, 3), start);
        cpu_write(word_addr(n, 4), {2'b00, pal, 1'b0, bank, 2'b00, prio});
        cpu_write(word_addr(n, 5), 16'h0000);
    endtask

    task automatic load_end(input int n);
        cpu_write(word_addr(n, 0), {`OBJ_END_MARK, 8'h00});
    endtask

    task automatic clear_expect();
        for (int h = 0; h < 512; h++) exp_line[h] = BLANK;
    endtask

    // Paint one object into the model, offset as written back to word 5
    task automatic expect_object(input obj_pkg::xpos_t x, input obj_pkg::tbl_word_t off,
                                 input obj_pkg::bank_t bank, input obj_pkg::pal_t pal,
                                 input obj_pkg::prio_t prio);
        obj_pkg::rom_addr_t a;
        obj_pkg::rom_word_t w;
        obj_pkg::color_t    c;
        obj_pkg::xpos_t     px;
        for (int k = 0; k < 16; k++) begin
            if (off[15]) begin
                a = {bank, off[14:0] - 15'(k / 4)};  // Flip counts down
                w = rom_word(a);
                c = w[4 * (k % 4) +: 4];             // Low nibble first
            end else begin
                a = {bank, off[14:0] + 15'(k / 4)};
                w = rom_word(a);
                c = w[12 - 4 * (k % 4) +: 4];
            end
            px = x + 9'(k);  // Wraps at 512
            if (c != `OBJ_TRANSPARENT) exp_line[px] = {prio, pal, c};
        end
    endtask

    // Draw line, swap with no scan, then sweep the drawn half
    task automatic run_line(input obj_pkg::vpos_t vline);
        vrender = vline;
        hstart  = 1'b1;
        @(posedge clk);
        #2;
        hstart = 1'b0;
        repeat (600) @(posedge clk);
        #2;
        vrender = 9'd255;  // Off screen
        hstart  = 1'b1;
        @(posedge clk);
        #2;
        hstart = 1'b0;
        for (int h = 0; h < 512; h++) begin
            hdump = obj_pkg::xpos_t'(h);
            @(posedge clk);
            #2;
            got_line[h] = pix;
        end
    endtask

    task automatic check_pix(input string what, input obj_pkg::obj_pix_t exp,
                             input obj_pkg::obj_pix_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input obj_pkg::tbl_word_t exp,
                              input obj_pkg::tbl_word_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_line();
        for (int h = 0; h < 512; h++) begin
            check_pix($sformatf("pix %0d", h), exp_line[h], got_line[h]);
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        start_errs = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == start_errs) begin
            $display("test %s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d mismatches", test_name, err_cnt - start_errs);
        end
    endtask

    task automatic test_single();
        start_test("single_object");
        load_entry(0, 8'd20, 8'd40, 9'd100, 16'h0004, 16'h0120, 6'h15, 3'd5, 2'd2);
        load_end(1);
        clear_expect();
        expect_object(9'd100, 16'h0124, 3'd5, 6'h15, 2'd2);
        run_line(9'd20);
        compare_line();
        end_test();
    endtask

    task automatic test_skip_end();
        start_test("skip_and_end");
        load_entry(0, 8'd60, 8'd80, 9'd10, 16'h0001, 16'h0010, 6'h01, 3'd1, 2'd0);  // Off line
        load_entry(1, 8'd50, 8'd50, 9'd30, 16'h0001, 16'h0020, 6'h02, 3'd1, 2'd0);  // Bad
        load_entry(2, 8'd50, 8'd60, 9'd200, 16'h0002, 16'h0400, 6'h33, 3'd3, 2'd3);
        load_end(3);
        load_entry(4, 8'd50, 8'd60, 9'd300, 16'h0001, 16'h0040, 6'h04, 3'd2, 2'd1);
        clear_expect();
        expect_object(9'd200, 16'h0402, 3'd3, 6'h33, 2'd3);
        run_line(9'd50);
        compare_line();
        // Low byte of 224 falls in this zone, but the line is not rendered
        load_entry(0, 8'd220, 8'd232, 9'd10, 16'h0001, 16'h0010, 6'h01, 3'd1, 2'd0);
        clear_expect();
        run_line(9'd224);
        compare_line();
        end_test();
    endtask

    task automatic test_write_back();
        obj_pkg::tbl_word_t got, off0, off1;
        start_test("offset_write_back");
        load_entry(0, 8'd100, 8'd110, 9'd20, 16'h0010, 16'h0200, 6'h0A, 3'd4, 2'd1);
        load_entry(1, 8'd100, 8'd110, 9'd60, 16'hFFF8, 16'h0300, 6'h0B, 3'd6, 2'd2);  // -8
        load_end(2);
        for (int i = 1; i <= 3; i++) begin
            run_line(obj_pkg::vpos_t'(99 + i));
            off0 = 16'h0200 + 16'(i) * 16'h0010;
            off1 = 16'h0300 + 16'(i) * 16'hFFF8;
            cpu_read(word_addr(0, 5), got);
            check_word($sformatf("line %0d obj 0 word 5", i), off0, got);
            cpu_read(word_addr(1, 5), got);
            check_word($sformatf("line %0d obj 1 word 5", i), off1, got);
            clear_expect();
            expect_object(9'd20, off0, 3'd4, 6'h0A, 2'd1);
            expect_object(9'd60, off1, 3'd6, 6'h0B, 2'd2);
            compare_line();
        end
        end_test();
    endtask

    task automatic test_flip();
        start_test("flip");
        // Starts near the right edge, wraps into x = 0
        load_entry(0, 8'd30, 8'd31, 9'd505, 16'h0002, 16'h8040, 6'h2A, 3'd2, 2'd1);
        load_end(1);
        clear_expect();
        expect_object(9'd505, 16'h8042, 3'd2, 6'h2A, 2'd1);
        run_line(9'd30);
        compare_line();
        end_test();
    endtask

    task automatic test_overlap();
        start_test("overlap");
        for (int w = 0; w < 4; w++) begin
            rom_mem[12'h501 + w] = {4'(w + 1), 4'(w + 5), 4'(w + 9), 4'h2};  // All opaque
            rom_mem[12'h601 + w] = {4'hF, 4'(w + 1), 4'(w + 3), 4'hF};      // Holes
        end
        load_entry(0, 8'd80, 8'd90, 9'd150, 16'h0001, 16'h0500, 6'h11, 3'd0, 2'd0);
        load_entry(1, 8'd80, 8'd90, 9'd158, 16'h0001, 16'h0600, 6'h22, 3'd0, 2'd3);
        load_end(2);
        clear_expect();
        expect_object(9'd150, 16'h0501, 3'd0, 6'h11, 2'd0);
        expect_object(9'd158, 16'h0601, 3'd0, 6'h22, 2'd3);  // Later wins
        run_line(9'd80);
        compare_line();
        end_test();
    endtask

    task automatic test_read_clear();
        start_test("read_clear");
        load_entry(0, 8'd120, 8'd130, 9'd64, 16'h0003, 16'h0700, 6'h3F, 3'd7, 2'd2);
        load_end(1);
        clear_expect();
        expect_object(9'd64, 16'h0703, 3'd7, 6'h3F, 2'd2);
        run_line(9'd120);
        compare_line();
        load_end(0);  // Empty list, same half comes back
        clear_expect();
        run_line(9'd121);
        compare_line();
        end_test();
    endtask

    initial begin
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_din  = '0;
        cpu_we   = 1'b0;
        hstart   = 1'b0;
        vrender  = 9'd255;
        hdump    = '0;
        rom_data = '0;
        fill_rom();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        test_single();
        test_skip_end();
        test_write_back();
        test_flip();
        test_overlap();
        test_read_clear();
        $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 NUM_TESTS, fail_cnt, err_cnt, UUT.u_scan.u_props.assert_errs);
        if (err_cnt == 0 && UUT.u_scan.u_props.assert_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- testbench/obj_video_props.sv
`timescale 1ns/10ps

module obj_video_props (
    input logic               clk,
    input logic               rst,
    input logic               dr_start,
    input logic               dr_busy,   // Drawer busy, seen on the scanner's port
    input logic               tbl_we,
    input obj_pkg::tbl_addr_t tbl_addr
);

    int assert_errs = 0;  // Failed assertions so far

    // No command into a busy drawer
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> !dr_busy)
        else begin
            $error("dr_start asserted while dr_busy is high");
            assert_errs++;
        end

    a_start_pulse: assert property (@(posedge clk) disable iff (rst)
        dr_start |=> !dr_start)  // Single-cycle strobe
        else begin
            $error("dr_start longer than one cycle");
            assert_errs++;
        end

    // Four words of one fetch and four pixels each
    a_busy_len: assert property (@(posedge clk) disable iff (rst)
        $rose(dr_busy) |-> dr_busy [*20] ##1 !dr_busy)
        else begin
            $error("dr_busy not high for exactly 20 cycles");
            assert_errs++;
        end

    // Write-back only ever lands on word 5 of an entry
    a_we_word5: assert property (@(posedge clk) disable iff (rst)
        tbl_we |-> tbl_addr[2:0] == 3'd5)
        else begin
            $error("table write outside word 5");
            assert_errs++;
        end

endmodule

bind obj_scan obj_video_props u_props (
    .clk      (clk),
    .rst      (rst),
    .dr_start (dr_start),
    .dr_busy  (dr_busy),
    .tbl_we   (tbl_we),
    .tbl_addr (tbl_addr)
);

//--- design/obj_video.sv
`timescale 1ns/10ps

module obj_video (
    input  logic               clk,
    input  logic               rst,
    // CPU access to the object table
    input  obj_pkg::tbl_addr_t cpu_addr,
    input  obj_pkg::tbl_word_t cpu_din,
    input  logic               cpu_we,
    output obj_pkg::tbl_word_t cpu_dout,
    // Video timing
    input  logic               hstart,
    input  obj_pkg::vpos_t     vrender,
    input  obj_pkg::xpos_t     hdump,
    // Graphics ROM
    output obj_pkg::rom_addr_t rom_addr,
    input  obj_pkg::rom_word_t rom_data,
    output obj_pkg::obj_pix_t  pix
);

    // Scanner to table
    obj_pkg::tbl_addr_t tbl_addr;
    obj_pkg::tbl_word_t tbl_din, tbl_dout;
    logic               tbl_we;

    // Draw command
    logic               dr_start, dr_busy;
    obj_pkg::xpos_t     dr_xpos;
    obj_pkg::tbl_word_t dr_offset;
    obj_pkg::bank_t     dr_bank;
    obj_pkg::pal_t      dr_pal;
    obj_pkg::prio_t     dr_prio;

    // Drawer to line buffer
    logic               buf_we;
    obj_pkg::xpos_t     buf_addr;
    obj_pkg::obj_pix_t  buf_data;

    obj_table_ram u_ram (
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .cpu_dout (cpu_dout),
        .tbl_addr (tbl_addr),
        .tbl_din  (tbl_din),
        .tbl_we   (tbl_we),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .tbl_addr  (tbl_addr),
        .tbl_dout  (tbl_dout),
        .tbl_din   (tbl_din),
        .tbl_we    (tbl_we),
        .hstart    (hstart),
        .vrender   (vrender),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy),
        .dr_xpos   (dr_xpos),
        .dr_offset (dr_offset),
        .dr_bank   (dr_bank),
        .dr_pal    (dr_pal),
        .dr_prio   (dr_prio)
    );

    obj_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy),
        .dr_xpos   (dr_xpos),
        .dr_offset (dr_offset),
        .dr_bank   (dr_bank),
        .dr_pal    (dr_pal),
        .dr_prio   (dr_prio),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .buf_we    (buf_we),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data)
    );

    obj_line_buffer u_lbuf (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .hdump    (hdump),
        .pix      (pix)
    );

endmodule

//--- design/obj_line_buffer.sv
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_line_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    // Drawer side
    input  logic              buf_we,
    input  obj_pkg::xpos_t    buf_addr,
    input  obj_pkg::obj_pix_t buf_data,
    // Video side
    input  obj_pkg::xpos_t    hdump,
    output obj_pkg::obj_pix_t pix
);

    localparam int DEPTH = 2 << `OBJ_LINE_AW;  // Both halves

    localparam obj_pkg::obj_pix_t CLEAR = obj_pkg::obj_pix_t'({8'h00, `OBJ_TRANSPARENT});

    obj_pkg::obj_pix_t mem [0:DEPTH-1];

    logic [DEPTH-1:0] valid;  // Cell holds a drawn pixel
    logic             wr_sel; // Half being drawn into
    logic             rd_ok;
    obj_pkg::obj_pix_t rd_q;

    logic [`OBJ_LINE_AW:0] wr_cell, rd_cell;

    assign wr_cell = {wr_sel, buf_addr};
    assign rd_cell = {~wr_sel, hdump};  // Other half goes to the screen

    // Read then clear, drawer writes the other half
    always_ff @(posedge clk) begin
        rd_q         <= mem[rd_cell];
        mem[rd_cell] <= CLEAR;
        if (buf_we) begin
            mem[wr_cell] <= buf_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_sel <= 1'b0;
            valid  <= '0;  // Both halves empty
            rd_ok  <= 1'b0;
        end else begin
            if (hstart) begin
                wr_sel <= ~wr_sel;  // Swap halves
            end
            rd_ok          <= valid[rd_cell];
            valid[rd_cell] <= 1'b0;
            if (buf_we) begin
                valid[wr_cell] <= 1'b1;
            end
        end
    end

    // Empty cells show transparent, one cycle after hdump
    assign pix = rd_ok ? rd_q : CLEAR;

endmodule

//--- design/obj_draw.sv
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_draw (
    input  logic               clk,
    input  logic               rst,
    // Command from the scanner
    input  logic               dr_start,
    output logic               dr_busy,
    input  obj_pkg::xpos_t     dr_xpos,
    input  obj_pkg::tbl_word_t dr_offset,
    input  obj_pkg::bank_t     dr_bank,
    input  obj_pkg::pal_t      dr_pal,
    input  obj_pkg::prio_t     dr_prio,
    // Graphics ROM
    output obj_pkg::rom_addr_t rom_addr,
    input  obj_pkg::rom_word_t rom_data,
    // Line buffer write side
    output logic               buf_we,
    output obj_pkg::xpos_t     buf_addr,
    output obj_pkg::obj_pix_t  buf_data
);

    obj_pkg::draw_state_t st;

    logic [3:0] pix_cnt;  // {word, nibble}

    // Latched command
    logic           flip;
    logic [14:0]    waddr;  // ROM word within the bank
    obj_pkg::bank_t bank;
    obj_pkg::xpos_t x0;
    obj_pkg::pal_t  pal;
    obj_pkg::prio_t prio;

    logic [1:0]      nib, sel;
    logic            word_done, last_word;
    obj_pkg::color_t color;

    assign nib       = pix_cnt[1:0];
    assign sel       = flip ? nib : ~nib;  // Low nibble first when flipped
    assign color     = rom_data[4*sel +: 4];
    assign word_done = (nib == 2'd3);
    assign last_word = (pix_cnt[3:2] == 2'(`OBJ_ROM_WORDS - 1));

    assign dr_busy  = (st != obj_pkg::DR_IDLE);
    assign rom_addr = {bank, waddr};  // Held through the pixel cycles

    // Pixel goes straight to the buffer, colour F never written
    assign buf_we   = (st == obj_pkg::DR_PIXELS) && (color != `OBJ_TRANSPARENT);
    assign buf_addr = x0 + obj_pkg::xpos_t'(pix_cnt);  // Wraps at 512
    assign buf_data = {prio, pal, color};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= obj_pkg::DR_IDLE;
            pix_cnt <= '0;
        end else begin
            case (st)
                obj_pkg::DR_IDLE: begin
                    pix_cnt <= '0;
                    if (dr_start) begin
                        st <= obj_pkg::DR_FETCH;
                    end
                end
                obj_pkg::DR_FETCH: st <= obj_pkg::DR_PIXELS;  // Data next cycle
                obj_pkg::DR_PIXELS: begin
                    pix_cnt <= pix_cnt + 4'd1;
                    if (word_done) begin
                        st <= last_word ? obj_pkg::DR_IDLE : obj_pkg::DR_FETCH;
                    end
                end
                default: st <= obj_pkg::DR_IDLE;
            endcase
        end
    end

    // Command latch and ROM address stepping
    always_ff @(posedge clk) begin
        if (st == obj_pkg::DR_IDLE && dr_start) begin
            flip  <= dr_offset[15];
            waddr <= dr_offset[14:0];
            bank  <= dr_bank;
            x0    <= dr_xpos;
            pal   <= dr_pal;
            prio  <= dr_prio;
        end else if (st == obj_pkg::DR_PIXELS && word_done) begin
            waddr <= flip ? waddr - 15'd1 : waddr + 15'd1;  // Down when flipped
        end
    end

endmodule

//--- design/obj_scan.sv
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_scan (
    input  logic               clk,
    input  logic               rst,
    // Table port
    output obj_pkg::tbl_addr_t tbl_addr,
    input  obj_pkg::tbl_word_t tbl_dout,
    output obj_pkg::tbl_word_t tbl_din,
    output logic               tbl_we,
    // Video timing
    input  logic               hstart,
    input  obj_pkg::vpos_t     vrender,
    // Draw command
    output logic               dr_start,
    input  logic               dr_busy,
    output obj_pkg::xpos_t     dr_xpos,
    output obj_pkg::tbl_word_t dr_offset,  // Bit 15 is flip
    output obj_pkg::bank_t     dr_bank,
    output obj_pkg::pal_t      dr_pal,
    output obj_pkg::prio_t     dr_prio
);

    obj_pkg::scan_state_t st;

    logic [7:0] cur_obj;  // Entry being looked at
    logic [2:0] idx;      // Word requested this cycle
    logic       stall;    // Read data not yet valid

    // Entry fields
    logic               first;  // First line of the object
    obj_pkg::xpos_t     xpos;
    obj_pkg::tbl_word_t pitch;
    obj_pkg::tbl_word_t offset;
    obj_pkg::bank_t     bank;
    obj_pkg::pal_t      pal;
    obj_pkg::prio_t     prio;

    logic [7:0]         top, bottom, vline;
    logic               inzone, endmark, last_obj;
    obj_pkg::tbl_word_t next_off;

    assign tbl_addr = {cur_obj, idx};

    assign top     = tbl_dout[7:0];  // Valid in ZONE only
    assign bottom  = tbl_dout[15:8];
    assign vline   = vrender[7:0];
    // Never true when top is not below bottom
    assign inzone  = (vline >= top) && (vline < bottom);
    assign endmark = bottom >= `OBJ_END_MARK;
    assign last_obj = &cur_obj;

    // Word 3 on the first line, word 5 after that; sum wraps for negative pitch
    assign next_off = (first ? offset : tbl_dout) + pitch;

    assign tbl_din = next_off;
    assign tbl_we  = (st == obj_pkg::SC_WRBACK);  // Address is word 5 here

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= obj_pkg::SC_IDLE;
            cur_obj  <= '0;
            idx      <= '0;
            stall    <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            case (st)
                obj_pkg::SC_IDLE: begin
                    cur_obj <= '0;
                    idx     <= '0;
                    stall   <= 1'b1;  // Word 0 read still pending
                    if (hstart && vrender < `OBJ_VISIBLE) begin
                        st <= obj_pkg::SC_ZONE;
                    end
                end
                obj_pkg::SC_ZONE: begin
                    if (stall) begin
                        idx   <= 3'd1;
                        stall <= 1'b0;
                    end else if (endmark) begin
                        st <= obj_pkg::SC_IDLE;  // List done
                    end else if (!inzone) begin
                        // Skip, two cycles per entry
                        if (last_obj) begin
                            st <= obj_pkg::SC_IDLE;
                        end else begin
                            cur_obj <= cur_obj + 8'd1;
                            idx     <= '0;
                            stall   <= 1'b1;
                        end
                    end else begin
                        idx <= 3'd2;
                        st  <= obj_pkg::SC_XPOS;
                    end
                end
                obj_pkg::SC_XPOS: begin
                    idx <= 3'd3;
                    st  <= obj_pkg::SC_PITCH;
                end
                obj_pkg::SC_PITCH: begin
                    idx <= 3'd4;
                    st  <= obj_pkg::SC_OFFSET;
                end
                obj_pkg::SC_OFFSET: begin
                    idx <= 3'd5;  // Held through write-back
                    st  <= obj_pkg::SC_ATTR;
                end
                obj_pkg::SC_ATTR:   st <= obj_pkg::SC_WRBACK;
                obj_pkg::SC_WRBACK: st <= obj_pkg::SC_ISSUE;
                obj_pkg::SC_ISSUE: begin
                    if (!dr_busy) begin
                        dr_start <= 1'b1;
                        if (last_obj) begin
                            st <= obj_pkg::SC_IDLE;
                        end else begin
                            cur_obj <= cur_obj + 8'd1;
                            idx     <= '0;
                            stall   <= 1'b1;
                            st      <= obj_pkg::SC_ZONE;
                        end
                    end else if (hstart) begin
                        st <= obj_pkg::SC_IDLE;  // Line over, drop the rest
                    end
                end
                default: st <= obj_pkg::SC_IDLE;
            endcase
        end
    end

    // Field capture and command payload
    always_ff @(posedge clk) begin
        case (st)
            obj_pkg::SC_ZONE:   first  <= (top == vline);
            obj_pkg::SC_XPOS:   xpos   <= tbl_dout[8:0];
            obj_pkg::SC_PITCH:  pitch  <= tbl_dout;
            obj_pkg::SC_OFFSET: offset <= tbl_dout;
            obj_pkg::SC_ATTR: begin
                pal  <= tbl_dout[13:8];
                bank <= tbl_dout[6:4];
                prio <= tbl_dout[1:0];
            end
            obj_pkg::SC_WRBACK: offset <= next_off;  // Drawn with the new offset
            obj_pkg::SC_ISSUE: begin
                if (!dr_busy) begin
                    dr_xpos   <= xpos;
                    dr_offset <= offset;
                    dr_bank   <= bank;
                    dr_pal    <= pal;
                    dr_prio   <= prio;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- design/obj_table_ram.sv
`timescale 1ns/10ps
`include "obj_settings.svh"

module obj_table_ram (
    input  logic               clk,
    // CPU side
    input  obj_pkg::tbl_addr_t cpu_addr,
    input  obj_pkg::tbl_word_t cpu_din,
    input  logic               cpu_we,
    output obj_pkg::tbl_word_t cpu_dout,
    // Scanner side
    input  obj_pkg::tbl_addr_t tbl_addr,
    input  obj_pkg::tbl_word_t tbl_din,
    input  logic               tbl_we,
    output obj_pkg::tbl_word_t tbl_dout
);

    localparam int DEPTH = 1 << `OBJ_TBL_AW;

    obj_pkg::tbl_word_t mem [0:DEPTH-1];

    logic collide;  // Both ports on one word

    assign collide = cpu_we && tbl_we && (cpu_addr == tbl_addr);

    // Writes, CPU has priority
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        if (tbl_we && !collide) begin
            mem[tbl_addr] <= tbl_din;  // Offset write-back
        end
    end

    // Registered reads, one cycle latency on each port
    always_ff @(posedge clk) begin
        cpu_dout <= mem[cpu_addr];
        tbl_dout <= mem[tbl_addr];
    end

endmodule

//--- design/obj_pkg.sv
`include "obj_settings.svh"

package obj_pkg;

    typedef logic [`OBJ_TBL_AW-1:0]  tbl_addr_t;  // {object, word}
    typedef logic [15:0]             tbl_word_t;
    typedef logic [`OBJ_LINE_AW-1:0] xpos_t;      // Also hdump
    typedef logic [8:0]              vpos_t;
    typedef logic [17:0]             rom_addr_t;  // {bank, offset[14:0]}
    typedef logic [15:0]             rom_word_t;  // Four 4-bit pixels
    typedef logic [2:0]              bank_t;
    typedef logic [5:0]              pal_t;
    typedef logic [1:0]              prio_t;
    typedef logic [3:0]              color_t;

    // One buffered pixel: {prio, pal, colour}
    typedef logic [11:0]             obj_pix_t;

    // Table walk
    typedef enum logic [2:0] {
        SC_IDLE,
        SC_ZONE,    // Word 0, top and bottom
        SC_XPOS,
        SC_PITCH,
        SC_OFFSET,  // Word 3, start offset and flip
        SC_ATTR,    // Word 4, palette, bank, priority
        SC_WRBACK,  // Word 5 updated here
        SC_ISSUE
    } scan_state_t;

    // Object drawing
    typedef enum logic [1:0] {
        DR_IDLE,
        DR_FETCH,
        DR_PIXELS
    } draw_state_t;

endpackage

//--- design/obj_settings.svh
`ifndef OBJ_SETTINGS_SVH
`define OBJ_SETTINGS_SVH

// Object table, 256 entries of 8 words
`define OBJ_TBL_AW 11

// First line that is not rendered
`define OBJ_VISIBLE 224

// Bottom value that ends the list
`define OBJ_END_MARK 8'hF0

// Graphics ROM words per 16-pixel object
`define OBJ_ROM_WORDS 4

`define OBJ_TRANSPARENT 4'hF  // Colour index never written

// Line buffer half, one cell per hdump position
`define OBJ_LINE_AW 9

`endif
